//--- source/ddr_ctrl_settings.svh
`ifndef DDR_CTRL_SETTINGS_SVH
`define DDR_CTRL_SETTINGS_SVH

// Memory geometry
`define DDR_BANK_BITS    3
`define DDR_ROW_BITS     14
`define DDR_COL_BITS     10
`define DDR_DATA_BITS    16
`define DDR_BURST_LEN    8
`define DDR_PARITY_BITS  1      // Byte select within a 16-bit word
`define DDR_ADDR_BITS    28
`define DDR_BURST_BITS   128

// Timing in ddr_clock_i cycles
`define DDR_T_RCD        3
`define DDR_T_RP         4
`define DDR_T_RFC        10
`define DDR_T_REFI       200
`define DDR_CL           5
`define DDR_CWL          5
`define DDR_T_WR         5

// APB register map
`define DDR_APB_ADDR_BITS 16
`define DDR_REG_RESET     16'h0000
`define DDR_REG_OVR_CMD   16'h0004
`define DDR_REG_OVR_ADDR  16'h0008
`define DDR_REG_STATUS    16'h000C

`endif

//--- source/ddr_ctrl_pkg.sv
`include "ddr_ctrl_settings.svh"

package ddr_ctrl_pkg;

    // Active-low command pins
    typedef struct packed {
        logic cs_n;
        logic ras_n;
        logic cas_n;
        logic we_n;
    } ddr_cmd_t;

    localparam ddr_cmd_t CMD_NOP      = 4'b0111;
    localparam ddr_cmd_t CMD_ACTIVATE = 4'b0011;
    localparam ddr_cmd_t CMD_READ     = 4'b0101;
    localparam ddr_cmd_t CMD_WRITE    = 4'b0100;
    localparam ddr_cmd_t CMD_REFRESH  = 4'b0001;

    typedef struct packed {
        logic [`DDR_BANK_BITS-1:0]   bank;
        logic [`DDR_ROW_BITS-1:0]    row;
        logic [`DDR_COL_BITS-1:0]    col;
        logic [`DDR_PARITY_BITS-1:0] parity;
    } ddr_addr_t;

    typedef struct packed {
        ddr_addr_t                  addr;
        logic                       write;
        logic [`DDR_BURST_BITS-1:0] wdata;   // Word i in bits 16i up
    } data_req_t;

    typedef struct packed {
        logic        pulse;
        ddr_cmd_t    cmd;
        logic [31:0] addr;   // Bank in the top bits
    } ovr_req_t;

    typedef struct packed {
        logic ddr_reset_n;
        logic phy_reset_n;
        logic run;
        logic odt_force;
        logic cke;
    } ctrl_mode_t;

    typedef enum logic [2:0] {
        PRECHARGED,
        ACTIVATE,
        OP,
        READ,
        READ_END,
        WRITE,
        WRITE_END
    } bank_state_e;

endpackage

//--- source/ddr_ctrl_regs.sv
`timescale 1ns/1ps
`include "ddr_ctrl_settings.svh"

module ddr_ctrl_regs (
    input  logic                          ddr_clock_i,
    input  logic                          rst_n_i,
    input  logic [`DDR_APB_ADDR_BITS-1:0] paddr_i,
    input  logic                          psel_i,
    input  logic                          penable_i,
    input  logic                          pwrite_i,
    input  logic [31:0]                   pwdata_i,
    output logic [31:0]                   prdata_o,
    output logic                          pready_o,
    output logic                          pslverr_o,
    input  logic                          status_busy_i,
    output ddr_ctrl_pkg::ctrl_mode_t      mode_o,
    output ddr_ctrl_pkg::ovr_req_t        ovr_o
);
    import ddr_ctrl_pkg::*;

    logic [31:0] reset_state_q;
    logic [31:0] ovr_addr_q;
    ddr_cmd_t    ovr_cmd_q;
    logic        ovr_pulse_q;
    logic        access;
    logic        bad_access;

    assign access = psel_i && penable_i;

    // Reset register layout, bit 2 is spare
    assign mode_o.ddr_reset_n = reset_state_q[0];
    assign mode_o.phy_reset_n = reset_state_q[1];
    assign mode_o.run         = reset_state_q[3];
    assign mode_o.odt_force   = reset_state_q[4];
    assign mode_o.cke         = reset_state_q[5];

    always_comb begin
        prdata_o = '0;
        bad_access = 1'b0;
        case (paddr_i)
            `DDR_REG_RESET:    prdata_o = reset_state_q;
            `DDR_REG_OVR_ADDR: prdata_o = ovr_addr_q;
            `DDR_REG_OVR_CMD:  bad_access = !pwrite_i || mode_o.run;  // Write only, bypass only
            `DDR_REG_STATUS: begin
                prdata_o = {30'b0, mode_o.run, status_busy_i};
                bad_access = pwrite_i;
            end
            default: bad_access = 1'b1;
        endcase
    end

    assign pready_o  = 1'b1;   // No wait states
    assign pslverr_o = access && bad_access;

    always_ff @(posedge ddr_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            reset_state_q <= '0;
            ovr_addr_q <= '0;
            ovr_cmd_q <= CMD_NOP;
            ovr_pulse_q <= 1'b0;
        end else begin
            ovr_pulse_q <= 1'b0;
            if (access && pwrite_i && !bad_access) begin
                case (paddr_i)
                    `DDR_REG_RESET:    reset_state_q <= pwdata_i;
                    `DDR_REG_OVR_ADDR: ovr_addr_q <= pwdata_i;
                    `DDR_REG_OVR_CMD: begin
                        ovr_cmd_q <= pwdata_i[3:0];
                        ovr_pulse_q <= 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

    assign ovr_o = '{pulse: ovr_pulse_q, cmd: ovr_cmd_q, addr: ovr_addr_q};

    // Raw commands never reach the pins while the bank FSM owns them
    a_ovr_bypass_only: assert property (
        @(posedge ddr_clock_i) disable iff (!rst_n_i)
        $rose(ovr_pulse_q) |-> !mode_o.run
    );

endmodule

//--- source/ddr_bank_fsm.sv
`timescale 1ns/1ps
`include "ddr_ctrl_settings.svh"

module ddr_bank_fsm (
    input  logic                       ddr_clock_i,
    input  logic                       rst_n_i,
    input  ddr_ctrl_pkg::ctrl_mode_t   mode_i,
    input  ddr_ctrl_pkg::ovr_req_t     ovr_i,
    input  logic                       data_valid_i,
    input  ddr_ctrl_pkg::data_req_t    data_req_i,
    output logic                       data_ready_o,
    output logic                       rsp_valid_o,
    output ddr_ctrl_pkg::ddr_cmd_t     ddr_cmd_o,
    output logic [`DDR_BANK_BITS-1:0]  ddr_ba_o,
    output logic [`DDR_ROW_BITS-1:0]   ddr_addr_o,
    output logic                       ddr_odt_o,
    output logic                       ddr_cke_o,
    output logic                       data_write_o,
    output logic                       load_write_o,
    output logic [`DDR_BURST_BITS-1:0] write_burst_o,
    output logic                       status_busy_o
);
    import ddr_ctrl_pkg::*;

    localparam int REFI_W = $clog2(`DDR_T_REFI);

    bank_state_e       state_q;
    logic [7:0]        cnt_q;
    logic              cnt_zero_q;
    logic [REFI_W-1:0] refi_cnt_q;
    logic              refresh_pend_q;
    logic              refresh_go;
    logic              odt_q;
    logic              accept;
    data_req_t         req_q;

    assign data_ready_o  = mode_i.run && state_q == PRECHARGED && cnt_zero_q && !refresh_pend_q;
    assign accept        = data_valid_i && data_ready_o;
    assign refresh_go    = mode_i.run && state_q == PRECHARGED && cnt_zero_q && refresh_pend_q;
    assign load_write_o  = mode_i.run && state_q == WRITE && cnt_zero_q;  // Lanes start at CWL
    assign write_burst_o = req_q.wdata;
    assign status_busy_o = state_q != PRECHARGED || !cnt_zero_q;
    assign ddr_odt_o     = odt_q || mode_i.odt_force;

    always_ff @(posedge ddr_clock_i) begin
        if (accept) begin
            req_q <= data_req_i;
        end
    end

    // Refresh interval timer, frozen in bypass
    always_ff @(posedge ddr_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            refi_cnt_q <= REFI_W'(`DDR_T_REFI - 1);
            refresh_pend_q <= 1'b0;
        end else begin
            if (refresh_go) refresh_pend_q <= 1'b0;
            if (mode_i.run) begin
                if (refi_cnt_q == '0) begin
                    refi_cnt_q <= REFI_W'(`DDR_T_REFI - 1);
                    refresh_pend_q <= 1'b1;
                end else begin
                    refi_cnt_q <= refi_cnt_q - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge ddr_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= PRECHARGED;
            cnt_q <= '0;
            cnt_zero_q <= 1'b1;
            ddr_cmd_o <= CMD_NOP;
            ddr_ba_o <= '0;
            ddr_addr_o <= '0;
            ddr_cke_o <= 1'b0;
            odt_q <= 1'b0;
            data_write_o <= 1'b0;
            rsp_valid_o <= 1'b0;
        end else begin
            ddr_cmd_o <= CMD_NOP;
            ddr_ba_o <= '0;
            ddr_addr_o <= '0;
            ddr_cke_o <= mode_i.cke;
            rsp_valid_o <= 1'b0;
            if (!cnt_zero_q) begin
                cnt_q <= cnt_q - 8'd1;
                cnt_zero_q <= cnt_q == 8'd1;
            end
            if (!mode_i.run) begin
                if (ovr_i.pulse) begin
                    ddr_cmd_o <= ovr_i.cmd;
                    ddr_ba_o <= ovr_i.addr[31 -: `DDR_BANK_BITS];
                    ddr_addr_o <= ovr_i.addr[`DDR_ROW_BITS-1:0];
                end
            end else if (cnt_zero_q) begin
                case (state_q)
                    PRECHARGED: begin
                        if (refresh_go) begin
                            ddr_cmd_o <= CMD_REFRESH;
                            cnt_q <= 8'(`DDR_T_RFC);
                            cnt_zero_q <= 1'b0;
                        end else if (accept) begin
                            state_q <= ACTIVATE;
                        end
                    end
                    ACTIVATE: begin
                        ddr_cmd_o <= CMD_ACTIVATE;
                        ddr_ba_o <= req_q.addr.bank;
                        ddr_addr_o <= req_q.addr.row;
                        state_q <= OP;
                        cnt_q <= 8'(`DDR_T_RCD);
                        cnt_zero_q <= 1'b0;
                    end
                    OP: begin
                        ddr_ba_o <= req_q.addr.bank;
                        ddr_addr_o[`DDR_COL_BITS-1:0] <= req_q.addr.col;
                        ddr_addr_o[10] <= 1'b1;   // Auto precharge
                        cnt_zero_q <= 1'b0;
                        if (req_q.write) begin
                            ddr_cmd_o <= CMD_WRITE;
                            state_q <= WRITE;
                            cnt_q <= 8'(`DDR_CWL - 1);
                            data_write_o <= 1'b1;
                            odt_q <= 1'b1;
                        end else begin
                            ddr_cmd_o <= CMD_READ;
                            state_q <= READ;
                            cnt_q <= 8'(`DDR_CL);
                        end
                    end
                    WRITE: begin
                        state_q <= WRITE_END;
                        cnt_q <= 8'(`DDR_BURST_LEN / 2 - 1);
                        cnt_zero_q <= 1'b0;
                    end
                    WRITE_END: begin
                        data_write_o <= 1'b0;
                        odt_q <= 1'b0;
                        state_q <= PRECHARGED;
                        cnt_q <= 8'(`DDR_T_RP + `DDR_T_WR);
                        cnt_zero_q <= 1'b0;
                    end
                    READ: begin
                        state_q <= READ_END;
                        cnt_q <= 8'(`DDR_BURST_LEN / 2);
                        cnt_zero_q <= 1'b0;
                    end
                    READ_END: begin
                        rsp_valid_o <= 1'b1;   // Burst is on dq_burst_i now
                        state_q <= PRECHARGED;
                        cnt_q <= 8'(`DDR_T_RP);
                        cnt_zero_q <= 1'b0;
                    end
                    default: state_q <= PRECHARGED;
                endcase
            end
        end
    end

    // Row and refresh commands belong to run mode
    a_bypass_no_row_cmd: assert property (
        @(posedge ddr_clock_i) disable iff (!rst_n_i)
        !$past(mode_i.run) |-> ddr_cmd_o != CMD_ACTIVATE && ddr_cmd_o != CMD_REFRESH
    );

    // Once a request is taken the port stays closed while the bank is open
    a_ready_closed_after_accept: assert property (
        @(posedge ddr_clock_i) disable iff (!rst_n_i)
        accept |=> !data_ready_o && state_q != PRECHARGED
    );

endmodule

//--- source/ddr_burst_shift.sv
`timescale 1ns/1ps
`include "ddr_ctrl_settings.svh"

module ddr_burst_shift (
    input  logic                       ddr_clock_i,
    input  logic                       rst_n_i,
    input  logic                       load_write_i,
    input  logic [`DDR_BURST_BITS-1:0] write_burst_i,
    input  logic [`DDR_BURST_BITS-1:0] dq_burst_i,
    input  logic                       capture_i,
    output logic [`DDR_DATA_BITS-1:0]  dq_lane_o [1:0],
    output logic [`DDR_BURST_BITS-1:0] rsp_data_o
);
    localparam int W          = `DDR_DATA_BITS;
    localparam int HALF_WORDS = `DDR_BURST_LEN / 2;

    logic [HALF_WORDS*W-1:0]    lane_q [1:0];
    logic [`DDR_BURST_BITS-1:0] rsp_q;

    // Lane 0 carries the even words, lane 1 the odd ones
    for (genvar l = 0; l < 2; l++) begin : g_lane
        always_ff @(posedge ddr_clock_i or negedge rst_n_i) begin
            if (!rst_n_i) begin
                lane_q[l] <= '0;
            end else if (load_write_i) begin
                for (int w = 0; w < HALF_WORDS; w++) begin
                    lane_q[l][w*W +: W] <= write_burst_i[(2*w+l)*W +: W];
                end
            end else begin
                lane_q[l] <= lane_q[l] >> W;   // Next word down to the pins
            end
        end

        assign dq_lane_o[l] = lane_q[l][W-1:0];
    end

    always_ff @(posedge ddr_clock_i) begin
        if (capture_i) begin
            rsp_q <= dq_burst_i;
        end
    end

    // Live burst during the response cycle, then the held copy
    assign rsp_data_o = capture_i ? dq_burst_i : rsp_q;

endmodule

//--- source/ddr_ctrl_top.sv
`timescale 1ns/1ps
`include "ddr_ctrl_settings.svh"

module ddr_ctrl_top (
    input  logic                          ddr_clock_i,
    input  logic                          rst_n_i,
    input  logic [`DDR_APB_ADDR_BITS-1:0] paddr_i,
    input  logic                          psel_i,
    input  logic                          penable_i,
    input  logic                          pwrite_i,
    input  logic [31:0]                   pwdata_i,
    output logic [31:0]                   prdata_o,
    output logic                          pready_o,
    output logic                          pslverr_o,
    input  logic                          data_valid_i,
    input  ddr_ctrl_pkg::data_req_t       data_req_i,
    output logic                          data_ready_o,
    output logic                          rsp_valid_o,
    output logic [`DDR_BURST_BITS-1:0]    rsp_data_o,
    output ddr_ctrl_pkg::ddr_cmd_t        ddr_cmd_o,
    output logic [`DDR_BANK_BITS-1:0]     ddr_ba_o,
    output logic [`DDR_ROW_BITS-1:0]      ddr_addr_o,
    output logic                          ddr_odt_o,
    output logic                          ddr_cke_o,
    output logic                          ddr_reset_n_o,
    output logic                          ddr_phy_reset_n_o,
    output logic [`DDR_DATA_BITS-1:0]     dq_lane_o [1:0],
    output logic                          data_write_o,
    input  logic [`DDR_BURST_BITS-1:0]    dq_burst_i
);
    import ddr_ctrl_pkg::*;

    ctrl_mode_t                 mode;
    ovr_req_t                   ovr;
    logic                       status_busy;
    logic                       load_write;
    logic [`DDR_BURST_BITS-1:0] write_burst;

    assign ddr_reset_n_o     = mode.ddr_reset_n;
    assign ddr_phy_reset_n_o = mode.phy_reset_n;

    ddr_ctrl_regs i_regs (
        .ddr_clock_i   (ddr_clock_i),
        .rst_n_i       (rst_n_i),
        .paddr_i       (paddr_i),
        .psel_i        (psel_i),
        .penable_i     (penable_i),
        .pwrite_i      (pwrite_i),
        .pwdata_i      (pwdata_i),
        .prdata_o      (prdata_o),
        .pready_o      (pready_o),
        .pslverr_o     (pslverr_o),
        .status_busy_i (status_busy),
        .mode_o        (mode),
        .ovr_o         (ovr)
    );

    ddr_bank_fsm i_bank_fsm (
        .ddr_clock_i   (ddr_clock_i),
        .rst_n_i       (rst_n_i),
        .mode_i        (mode),
        .ovr_i         (ovr),
        .data_valid_i  (data_valid_i),
        .data_req_i    (data_req_i),
        .data_ready_o  (data_ready_o),
        .rsp_valid_o   (rsp_valid_o),
        .ddr_cmd_o     (ddr_cmd_o),
        .ddr_ba_o      (ddr_ba_o),
        .ddr_addr_o    (ddr_addr_o),
        .ddr_odt_o     (ddr_odt_o),
        .ddr_cke_o     (ddr_cke_o),   // Registered copy of mode.cke
        .data_write_o  (data_write_o),
        .load_write_o  (load_write),
        .write_burst_o (write_burst),
        .status_busy_o (status_busy)
    );

    ddr_burst_shift i_burst_shift (
        .ddr_clock_i   (ddr_clock_i),
        .rst_n_i       (rst_n_i),
        .load_write_i  (load_write),
        .write_burst_i (write_burst),
        .dq_burst_i    (dq_burst_i),
        .capture_i     (rsp_valid_o),
        .dq_lane_o     (dq_lane_o),
        .rsp_data_o    (rsp_data_o)
    );

endmodule

//--- tests/ddr_ctrl_tb.sv
`timescale 1ns/1ps
`include "ddr_ctrl_settings.svh"

module ddr_ctrl_tb;
    import ddr_ctrl_pkg::*;

    localparam int CLK_PERIOD      = 20;
    localparam int EXPECTED_CYCLES = 1300;
    localparam int HALF_BURST      = `DDR_BURST_LEN / 2;

    logic                          ddr_clock;
    logic                          rst_n;
    logic [`DDR_APB_ADDR_BITS-1:0] paddr;
    logic                          psel;
    logic                          penable;
    logic                          pwrite;
    logic [31:0]                   pwdata;
    logic [31:0]                   prdata;
    logic                          pready;
    logic                          pslverr;
    logic                          data_valid;
    data_req_t                     data_req;
    logic                          data_ready;
    logic                          rsp_valid;
    logic [`DDR_BURST_BITS-1:0]    rsp_data;
    ddr_cmd_t                      ddr_cmd;
    logic [`DDR_BANK_BITS-1:0]     ddr_ba;
    logic [`DDR_ROW_BITS-1:0]      ddr_addr;
    logic                          ddr_odt;
    logic                          ddr_cke;
    logic                          ddr_reset_n;
    logic                          ddr_phy_reset_n;
    logic [`DDR_DATA_BITS-1:0]     dq_lane [1:0];
    logic                          data_write;
    logic [`DDR_BURST_BITS-1:0]    dq_burst;

    logic [31:0] rand_state = 32'hc7fe_8d3e;
    string       cur_test;
    int          test_errs;
    int          total_errs;
    int          tests_run;
    int          tests_failed;

    ddr_ctrl_top i_ddr_ctrl_top (
        .ddr_clock_i       (ddr_clock),
        .rst_n_i           (rst_n),
        .paddr_i           (paddr),
        .psel_i            (psel),
        .penable_i         (penable),
        .pwrite_i          (pwrite),
        .pwdata_i          (pwdata),
        .prdata_o          (prdata),
        .pready_o          (pready),
        .pslverr_o         (pslverr),
        .data_valid_i      (data_valid),
        .data_req_i        (data_req),
        .data_ready_o      (data_ready),
        .rsp_valid_o       (rsp_valid),
        .rsp_data_o        (rsp_data),
        .ddr_cmd_o         (ddr_cmd),
        .ddr_ba_o          (ddr_ba),
        .ddr_addr_o        (ddr_addr),
        .ddr_odt_o         (ddr_odt),
        .ddr_cke_o         (ddr_cke),
        .ddr_reset_n_o     (ddr_reset_n),
        .ddr_phy_reset_n_o (ddr_phy_reset_n),
        .dq_lane_o         (dq_lane),
        .data_write_o      (data_write),
        .dq_burst_i        (dq_burst)
    );

    initial begin
        ddr_clock = 1'b0;
        forever #(CLK_PERIOD / 2) ddr_clock = ~ddr_clock;
    end

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    // Read data the PHY model returns, word i is base plus i
    function automatic logic [127:0] burst_pattern(input logic [2:0] bank,
                                                   input logic [13:0] row,
                                                   input logic [9:0] col);
        logic [15:0]  base;
        logic [127:0] b;
        base = 16'(bank) + 16'(row) + 16'(col);
        for (int i = 0; i < `DDR_BURST_LEN; i++) begin
            b[16*i +: 16] = base + 16'(i);
        end
        return b;
    endfunction

    function automatic data_req_t make_req(input logic is_write);
        data_req_t   r;
        logic [31:0] a;
        a = next_rand();
        r.addr.bank   = a[31:29];
        r.addr.row    = a[27:14];
        r.addr.col    = a[9:0];
        r.addr.parity = a[12];
        r.write       = is_write;
        for (int i = 0; i < 4; i++) begin
            r.wdata[32*i +: 32] = next_rand();
        end
        return r;
    endfunction

    task automatic next_cycle();
        @(posedge ddr_clock);
        #2;
    endtask

    task automatic note_mismatch(input string what, input logic [127:0] exp,
                                 input logic [127:0] act);
        $display("mismatch %s %s: expected %0h actual %0h", cur_test, what, exp, act);
        test_errs++;
        total_errs++;
    endtask

    task automatic fail_check(input string what);
        $display("error in %s: %s", cur_test, what);
        test_errs++;
        total_errs++;
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        test_errs = 0;
    endtask

    task automatic close_test();
        tests_run++;
        if (test_errs > 0) tests_failed++;
        $display("test %s: %s (%0d errors)", cur_test, test_errs > 0 ? "failed" : "passed",
                 test_errs);
    endtask

    // Setup phase now, access phase next cycle, returns 2 ns after the access edge
    task automatic write_reg(input logic [15:0] addr, input logic [31:0] data,
                             output logic err);
        paddr = addr;
        pwrite = 1'b1;
        pwdata = data;
        psel = 1'b1;
        penable = 1'b0;
        next_cycle();
        penable = 1'b1;
        #1;
        err = pslverr;
        if (pready !== 1'b1) fail_check("pready_o low in the access phase");
        next_cycle();
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic read_reg(input logic [15:0] addr, output logic [31:0] data,
                            output logic err);
        paddr = addr;
        pwrite = 1'b0;
        psel = 1'b1;
        penable = 1'b0;
        next_cycle();
        penable = 1'b1;
        #1;
        data = prdata;
        err = pslverr;
        if (pready !== 1'b1) fail_check("pready_o low in the access phase");
        next_cycle();
        psel = 1'b0;
        penable = 1'b0;
    endtask

    // PHY model, remembers the open row and answers each READ
    initial begin : phy_responder
        logic [13:0] open_row;
        open_row = '0;
        dq_burst = '0;
        forever begin
            next_cycle();
            if (ddr_cmd == CMD_ACTIVATE) begin
                open_row = ddr_addr;
            end else if (ddr_cmd == CMD_READ) begin
                dq_burst = burst_pattern(ddr_ba, open_row, ddr_addr[9:0]);
            end
        end
    end

    // Offers req, then holds nxt on the port while req is served
    task automatic serve_request(input data_req_t req, input logic hold_next,
                                 input data_req_t nxt);
        int           cyc;
        int           act_cyc;
        int           op_cyc;
        int           end_cyc;
        int           k;
        int           w;
        logic [13:0]  op_addr;
        logic [127:0] exp_rsp;
        cyc = 0;
        act_cyc = -1;
        op_cyc = -1;
        end_cyc = -1;
        op_addr = {3'b000, 1'b1, req.addr.col};
        exp_rsp = burst_pattern(req.addr.bank, req.addr.row, req.addr.col);
        data_req = req;
        data_valid = 1'b1;
        while (!data_ready && cyc < 500) begin   // Refresh may hold the port
            next_cycle();
            cyc++;
        end
        next_cycle();
        data_req = nxt;
        data_valid = hold_next;
        cyc = 0;
        do begin
            next_cycle();
            cyc++;
            k = cyc - op_cyc;
            if (ddr_cmd == CMD_ACTIVATE) begin
                if (cyc != 1) fail_check("ACTIVATE not one cycle after acceptance");
                if ({ddr_ba, ddr_addr} !== {req.addr.bank, req.addr.row}) begin
                    note_mismatch("ACTIVATE bank/row", 128'({req.addr.bank, req.addr.row}),
                                  128'({ddr_ba, ddr_addr}));
                end
                act_cyc = cyc;
            end else if (ddr_cmd == CMD_READ || ddr_cmd == CMD_WRITE) begin
                if (cyc != act_cyc + `DDR_T_RCD + 1) fail_check("column command off time");
                if (ddr_cmd !== (req.write ? CMD_WRITE : CMD_READ)) begin
                    note_mismatch("command", 128'(req.write ? CMD_WRITE : CMD_READ),
                                  128'(ddr_cmd));
                end
                if ({ddr_ba, ddr_addr} !== {req.addr.bank, op_addr}) begin
                    note_mismatch("column bank/address", 128'({req.addr.bank, op_addr}),
                                  128'({ddr_ba, ddr_addr}));
                end
                op_cyc = cyc;
                k = 0;
            end else if (ddr_cmd == CMD_REFRESH) begin
                if (end_cyc < 0) fail_check("REFRESH issued inside a request");
            end else if (ddr_cmd != CMD_NOP) begin
                fail_check("unexpected command on the pins");
            end
            if (op_cyc > 0 && req.write) begin
                if ({data_write, ddr_odt} !== {2{k < `DDR_CWL + HALF_BURST}}) begin
                    note_mismatch("data_write/odt", 128'({2{k < `DDR_CWL + HALF_BURST}}),
                                  128'({data_write, ddr_odt}));
                end
                if (k >= `DDR_CWL && k < `DDR_CWL + HALF_BURST) begin
                    w = 2 * (k - `DDR_CWL);   // Even word on lane 0, odd on lane 1
                    if ({dq_lane[1], dq_lane[0]} !== req.wdata[16*w +: 32]) begin
                        note_mismatch("write lanes", 128'(req.wdata[16*w +: 32]),
                                      128'({dq_lane[1], dq_lane[0]}));
                    end
                end
                if (k == `DDR_CWL + HALF_BURST) end_cyc = cyc;
            end
            if (rsp_valid) begin
                if (req.write || op_cyc < 0 || k != `DDR_CL + 2 + HALF_BURST) begin
                    fail_check("rsp_valid_o at the wrong cycle");
                end
                if (rsp_data !== exp_rsp) note_mismatch("read data", exp_rsp, rsp_data);
                end_cyc = cyc;
            end
        end while (!data_ready && cyc < 100);
        if (!data_ready) begin
            fail_check("data_ready_o never returned");
        end else if (end_cyc < 0) begin
            fail_check("request finished without its burst");
        end else if (cyc - end_cyc < (req.write ? `DDR_T_RP + `DDR_T_WR : `DDR_T_RP)) begin
            fail_check("data_ready_o returned before the precharge wait");
        end
    endtask

    task automatic registers_test();
        logic [31:0] a;
        logic [31:0] d;
        logic        err;
        begin_test("registers");
        if ({ddr_reset_n, ddr_cke, data_ready, rsp_valid, data_write, ddr_odt} !== 6'b0) begin
            fail_check("outputs not idle after reset");
        end
        if (ddr_cmd !== CMD_NOP) note_mismatch("reset command", 128'(CMD_NOP), 128'(ddr_cmd));
        write_reg(`DDR_REG_RESET, 32'h5a00_0023, err);
        read_reg(`DDR_REG_RESET, d, err);
        if (d !== 32'h5a00_0023) note_mismatch("RESET readback", 128'(32'h5a00_0023), 128'(d));
        a = next_rand();
        write_reg(`DDR_REG_OVR_ADDR, a, err);
        read_reg(`DDR_REG_OVR_ADDR, d, err);
        if (d !== a) note_mismatch("OVR_ADDR readback", 128'(a), 128'(d));
        next_cycle();
        if ({ddr_reset_n, ddr_phy_reset_n, ddr_cke} !== 3'b111) begin
            note_mismatch("reset pins", 128'(3'b111),
                          128'({ddr_reset_n, ddr_phy_reset_n, ddr_cke}));
        end
        read_reg(16'h0010, d, err);
        if (err !== 1'b1) fail_check("unknown offset gave no pslverr_o");
        close_test();
    endtask

    task automatic bypass_test();
        logic [31:0] a;
        logic        err;
        begin_test("bypass");
        a = next_rand();
        write_reg(`DDR_REG_OVR_ADDR, a, err);
        write_reg(`DDR_REG_OVR_CMD, {28'h0, CMD_READ}, err);
        if (err !== 1'b0) fail_check("override write rejected in bypass");
        if (ddr_cmd !== CMD_NOP) fail_check("override command came too early");
        next_cycle();
        if ({ddr_cmd, ddr_ba, ddr_addr} !== {CMD_READ, a[31:29], a[13:0]}) begin
            note_mismatch("override pins", 128'({CMD_READ, a[31:29], a[13:0]}),
                          128'({ddr_cmd, ddr_ba, ddr_addr}));
        end
        if (data_ready !== 1'b0) fail_check("data_ready_o high in bypass");
        next_cycle();
        if (ddr_cmd !== CMD_NOP) note_mismatch("after override", 128'(CMD_NOP), 128'(ddr_cmd));
        close_test();
    endtask

    task automatic write_test();
        logic [31:0] d;
        logic        err;
        begin_test("write");
        write_reg(`DDR_REG_RESET, 32'h0000_002b, err);   // Run, CKE, both resets released
        read_reg(`DDR_REG_STATUS, d, err);
        if (d !== 32'h0000_0002) note_mismatch("status", 128'(32'h2), 128'(d));
        write_reg(`DDR_REG_OVR_CMD, {28'h0, CMD_NOP}, err);
        if (err !== 1'b1) fail_check("override write accepted in run mode");
        serve_request(make_req(1'b1), 1'b0, '0);
        close_test();
    endtask

    task automatic read_test();
        begin_test("read");
        serve_request(make_req(1'b0), 1'b0, '0);
        close_test();
    endtask

    task automatic back_pressure_test();
        data_req_t r0;
        data_req_t r1;
        data_req_t r2;
        r0 = make_req(1'b1);
        r1 = make_req(1'b0);
        r2 = make_req(1'b1);
        begin_test("back_pressure");
        serve_request(r0, 1'b1, r1);
        serve_request(r1, 1'b1, r2);
        serve_request(r2, 1'b0, '0);
        close_test();
    endtask

    task automatic refresh_test();
        int n;
        n = 0;
        begin_test("refresh");
        repeat (1000) begin
            next_cycle();
            if (ddr_cmd == CMD_REFRESH) n++;
        end
        if (n < 1000 / `DDR_T_REFI - 1 || n > 1000 / `DDR_T_REFI) begin
            note_mismatch("REFRESH count", 128'(1000 / `DDR_T_REFI), 128'(n));
        end
        close_test();
    endtask

    initial begin : watchdog
        #(20 * EXPECTED_CYCLES * CLK_PERIOD);
        $display("timeout: run still going after %0d cycles", 20 * EXPECTED_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        rst_n = 1'b0;
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = '0;
        data_valid = 1'b0;
        data_req = '0;
        total_errs = 0;
        tests_run = 0;
        tests_failed = 0;
        repeat (3) @(posedge ddr_clock);
        #2;
        rst_n = 1'b1;
        registers_test();
        bypass_test();
        write_test();
        read_test();
        back_pressure_test();
        refresh_test();
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errs);
        if (total_errs == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+source
source/ddr_ctrl_pkg.sv
source/ddr_ctrl_regs.sv
source/ddr_bank_fsm.sv
source/ddr_burst_shift.sv
source/ddr_ctrl_top.sv
tests/ddr_ctrl_tb.sv

//--- Makefile
.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f compile.f --top-module ddr_ctrl_tb -o ddr_ctrl_sim
	@out="$$(./obj_dir/ddr_ctrl_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

lint:
	verilator --lint-only --timing -f compile.f --top-module ddr_ctrl_tb

clean:
	rm -rf obj_dir
